// ==== common/fpalu_pkg.sv ====
/* Shared widths, biases and types of the FP29i / FP16 arithmetic unit.
   Every design file refers to these by scoped name. */
package fpalu_pkg;

	// FP29i: sign, 6b exponent, 22b mantissa without hidden bit
	// Value = man * 2^(exp - 52), always kept denormalized
	typedef logic [5:0] exp_t;	// FP29i exponent, bias 31
	typedef logic [21:0] man_t;	// FP29i mantissa, right aligned

	// FP16 as seen by the multiplier
	// Hidden bit is 1 unless the exponent is zero
	typedef logic [4:0] hexp_t;	// FP16 exponent, bias 15

	// Adder word, one guard bit above the mantissa
	// Holds the carry of an add or the product of two significands
	typedef logic [22:0] sum_t;

	// Alignment shift or leading-zero count
	// Count of 23 is possible for an all-zero word
	typedef logic [4:0] shamt_t;

	// Operation select, one per valid cycle
	typedef enum logic {
		OP_ADD = 1'b0,	// FP29i + FP29i
		OP_MUL = 1'b1	// FP16 * FP16 -> FP29i
	} fpalu_op_t;

	// Exponent biases
	localparam int AL_EXP_BIAS = 31;	// FP29i
	localparam int ML_EXP_BIAS = 15;	// FP16

	// Multiplier geometry
	localparam int ML_MAN_BITS = 11;	// FP16 significand incl. hidden bit
	localparam int PP_BITS = 12;	// Booth partial product, one bit over the significand

	// Product re-bias in short
	//   y_exp = ea + eb - 2*ML_EXP_BIAS + AL_EXP_BIAS + 2 - lzc
	// The +2 covers the binary point of the 11x11 product
	// sitting two places below the FP29i mantissa scale

	// Add result in short
	//   y_exp = max(ea, eb) + 1 - lzc
	//   y_man = top 22 bits of (sum << lzc)
	// Exponents wrap, no overflow detection

	// Alignment
	//   smaller operand is shifted right by |ea - eb|
	//   bits shifted out are dropped, no sticky or rounding
	//   distance at or above the shift limit flushes it to zero

endpackage

// ==== common/fpalu_operand_if.sv ====
/* Stage-2 operand bundle from the alignment front end to the shared
   adder and normalizer. Driven from registers, read in stage 3. */
interface fpalu_operand_if;

	logic valid;	// Operation in this slot
	fpalu_pkg::fpalu_op_t op;
	logic skip;	// Add with zero L, R passes through
	fpalu_pkg::sum_t lhs;	// L, or R on skip
	fpalu_pkg::sum_t rhs;	// Aligned R, inverted on subtract
	logic sub;	// Signs differ, also adder carry-in
	fpalu_pkg::exp_t exp_a;	// Masked to 5b on multiply
	fpalu_pkg::exp_t exp_b;
	logic a_ge_b;	// A is L
	logic sign_a;
	logic sign_b;

	modport front (
		output valid, op, skip, lhs, rhs, sub,
		output exp_a, exp_b, a_ge_b, sign_a, sign_b
	);

	modport back (
		input valid, op, skip, lhs, rhs, sub,
		input exp_a, exp_b, a_ge_b, sign_a, sign_b
	);

endinterface

// ==== hw/align/operand_align.sv ====
/* Add-path front end: exponent compare, operand exchange, right alignment
   and zero bypass. Two register stages into the operand bundle. */
module operand_align #(
	parameter int ALIGN_SHIFT_MAX = 32	// Shift distance that gives zero
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  fpalu_pkg::fpalu_op_t op,
	input  logic                 a_sgn,
	input  fpalu_pkg::exp_t      a_exp,
	input  fpalu_pkg::man_t      a_man,
	input  logic                 b_sgn,
	input  fpalu_pkg::exp_t      b_exp,
	input  fpalu_pkg::man_t      b_man,
	fpalu_operand_if.front       o
);

	localparam int EW = $bits(fpalu_pkg::exp_t);

	logic [EW:0]          ediff;	// One extra bit for the borrow
	logic                 a_lt_b;
	fpalu_pkg::exp_t      d_abs;

	// Stage 1 registers
	logic                 v1;
	fpalu_pkg::fpalu_op_t op1;
	logic                 age1;	// A is L
	fpalu_pkg::exp_t      d1;	// |ea - eb|
	fpalu_pkg::man_t      lhs1;
	fpalu_pkg::man_t      rhs1;
	logic                 sub1;
	logic                 sa1, sb1;
	fpalu_pkg::exp_t      ea1, eb1;

	// Stage 2 combinational
	fpalu_pkg::man_t      rsh;
	fpalu_pkg::man_t      rsh_g;
	logic                 lhs_zero;

	// Stage 1: compare and exchange
	always_comb begin
		ediff = {1'b0, a_exp} - {1'b0, b_exp};
		a_lt_b = ediff[EW];	// Borrow out
		d_abs = a_lt_b ? fpalu_pkg::exp_t'(~ediff + 1'b1) : ediff[EW-1:0];
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op1 <= op;
			age1 <= ~a_lt_b;	// Tie keeps A as L
			d1 <= d_abs;
			lhs1 <= a_lt_b ? b_man : a_man;	// Exchange while the difference settles
			rhs1 <= a_lt_b ? a_man : b_man;
			sub1 <= a_sgn ^ b_sgn;
			sa1 <= a_sgn;
			sb1 <= b_sgn;
			if (op == fpalu_pkg::OP_MUL) begin
				// FP16 exponent lives in the low 5 bits
				ea1 <= fpalu_pkg::exp_t'(fpalu_pkg::hexp_t'(a_exp));
				eb1 <= fpalu_pkg::exp_t'(fpalu_pkg::hexp_t'(b_exp));
			end else begin
				ea1 <= a_exp;
				eb1 <= b_exp;
			end
		end
	end

	// Stage 2: align, zero detect, invert
	always_comb begin
		rsh = rhs1 >> fpalu_pkg::shamt_t'(d1);	// Truncating, zero fill
		rsh_g = (d1 >= ALIGN_SHIFT_MAX) ? '0 : rsh;	// Far below L
		lhs_zero = (lhs1 == '0);
	end

	always_ff @(posedge clk) begin
		o.op <= op1;
		o.skip <= (op1 == fpalu_pkg::OP_ADD) && lhs_zero;
		o.lhs <= lhs_zero ? {1'b0, rhs1} : {1'b0, lhs1};	// Bypass rides on lhs
		o.rhs <= sub1 ? ~{1'b0, rsh_g} : {1'b0, rsh_g};	// Ones complement, +1 via sub
		o.sub <= sub1;
		o.exp_a <= ea1;
		o.exp_b <= eb1;
		o.a_ge_b <= age1;
		o.sign_a <= sa1;
		o.sign_b <= sb1;
	end

	// Valid chain
	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			o.valid <= 1'b0;
		end else begin
			v1 <= in_valid;
			o.valid <= v1;
		end
	end

	// An accepted operation must carry a defined opcode
	assert property (@(posedge clk) disable iff (rst) in_valid |-> !$isunknown(op));

endmodule

// ==== hw/mul/booth_mul.sv ====
/* FP16 significand multiplier, radix-4 Booth with two partial sums.
   Partial products registered in stage 1, partial sums in stage 2. */
module booth_mul (
	input  logic                          clk,
	input  logic                          in_valid,
	input  fpalu_pkg::fpalu_op_t          op,
	input  fpalu_pkg::exp_t               a_exp,
	input  fpalu_pkg::man_t               a_man,
	input  fpalu_pkg::exp_t               b_exp,
	input  fpalu_pkg::man_t               b_man,
	output logic [fpalu_pkg::PP_BITS+6:0] ps0,	// pp0..pp2 with sign constants
	output logic [fpalu_pkg::PP_BITS+3:0] ps1,	// pp3..pp5, offset by 6
	output logic                          s2	// +1 of pp2 for stage 3
);

	localparam int ML = fpalu_pkg::ML_MAN_BITS;
	localparam int PP = fpalu_pkg::PP_BITS;
	localparam int NPP = 6;	// ceil((11 + 1) / 2) digits

	fpalu_pkg::hexp_t      ha_exp, hb_exp;
	logic [ML-1:0]         sig_a;	// Multiplicand
	logic [ML-1:0]         sig_b;	// Booth-encoded operand
	logic [2*NPP+1:0]      bcode;	// Zero padded both ends
	logic [NPP-1:0][PP-1:0] pp;
	logic [NPP-1:0]        neg;

	logic [NPP-1:0][PP-1:0] pp_r;
	logic [NPP-1:0]        neg_r;
	logic [PP+6:0]         ps0_c;
	logic [PP+3:0]         ps1_c;

	// One Booth digit as {negative, ones-complement partial product}
	function automatic logic [PP:0] booth_digit(input logic [ML-1:0] m, input logic [2:0] g);
		logic one;
		logic two;
		logic dneg;
		logic [PP-1:0] mag;
		one = g[0] ^ g[1];	// +-1
		two = (g == 3'b011) || (g == 3'b100);	// +-2
		dneg = g[2] & ~(g[1] & g[0]);	// 111 is a plain zero
		mag = one ? {1'b0, m} : (two ? {m, 1'b0} : '0);
		return {dneg, dneg ? ~mag : mag};
	endfunction

	// Hidden bit, or denormal fraction moved up one place
	always_comb begin
		ha_exp = fpalu_pkg::hexp_t'(a_exp);
		hb_exp = fpalu_pkg::hexp_t'(b_exp);
		sig_a = (ha_exp == '0) ? {a_man[ML-2:0], 1'b0} : {1'b1, a_man[ML-2:0]};
		sig_b = (hb_exp == '0) ? {b_man[ML-2:0], 1'b0} : {1'b1, b_man[ML-2:0]};
		bcode = {2'b00, sig_b, 1'b0};
	end

	// Partial product generation
	always_comb begin
		for (int k = 0; k < NPP; k++) begin
			{neg[k], pp[k]} = booth_digit(sig_a, bcode[2*k +: 3]);
		end
	end

	// Loaded only on multiplies so adds leave it quiet
	always_ff @(posedge clk) begin
		if (in_valid && op == fpalu_pkg::OP_MUL) begin
			pp_r <= pp;
			neg_r <= neg;
		end
	end

	// Reduction with sign-extension constants
	// First PP carries {~s, s, s}, the rest {1, ~s}
	// Each +1 correction sits under the next PP
	always_comb begin
		ps0_c = {4'b0000, ~neg_r[0], {2{neg_r[0]}}, pp_r[0]};
		ps0_c = ps0_c + {4'b0001, ~neg_r[1], pp_r[1], 1'b0, neg_r[0]};
		ps0_c = ps0_c + {2'b01, ~neg_r[2], pp_r[2], 1'b0, neg_r[1], 2'b00};
		ps1_c = {3'b001, ~neg_r[3], pp_r[3]};
		ps1_c = ps1_c + {1'b1, ~neg_r[4], pp_r[4], 1'b0, neg_r[3]};
		ps1_c = ps1_c + {pp_r[5], 1'b0, neg_r[4], 2'b00};	// Top digit is never negative
	end

	// Stays put when pp_r holds
	always_ff @(posedge clk) begin
		ps0 <= ps0_c;
		ps1 <= ps1_c;
		s2 <= neg_r[2];
	end

	// Sums rebuild the unsigned product with the top digit taken as positive
	assert property (@(posedge clk) $past(in_valid && op == fpalu_pkg::OP_MUL, 2) |->
		(({3'b000, ps0} + {ps1, 6'b000000} + {17'd0, s2, 4'b0000})
			== ({11'd0, $past(sig_a, 2)} * {11'd0, $past(sig_b, 2)})));

endmodule

// ==== hw/sum_normalize.sv ====
/* Shared back end with carry adder for add and product, leading-zero count,
   normalizing shift, exponent and sign. Output is combinational off stage 5. */
module sum_normalize (
	input  logic                          clk,
	input  logic                          rst,
	fpalu_operand_if.back                 i,
	input  logic [fpalu_pkg::PP_BITS+6:0] ps0,
	input  logic [fpalu_pkg::PP_BITS+3:0] ps1,
	input  logic                          s2,
	output logic                          out_valid,
	output logic                          y_sgn,
	output fpalu_pkg::exp_t               y_exp,
	output fpalu_pkg::man_t               y_man
);

	localparam int SW = $bits(fpalu_pkg::sum_t);

	// Stage 3 combinational
	fpalu_pkg::sum_t      add_l, add_r, add_y;
	logic                 add_c;

	// Stage 3 registers
	logic                 v3;
	fpalu_pkg::fpalu_op_t op3;
	logic                 skip3, age3, sa3, sb3;
	fpalu_pkg::exp_t      ea3, eb3;
	fpalu_pkg::sum_t      word_r;	// Adder result
	fpalu_pkg::man_t      byp_r;	// Bypass mantissa

	// Stage 4 registers
	fpalu_pkg::fpalu_op_t op4;
	logic                 skip4, age4, sa4, sb4;
	fpalu_pkg::exp_t      ea4, eb4;
	fpalu_pkg::shamt_t    lzc_r;
	fpalu_pkg::sum_t      word4_r;
	fpalu_pkg::man_t      byp4_r;

	// Stage 5 combinational
	fpalu_pkg::sum_t      norm_w;
	fpalu_pkg::exp_t      l_exp;

	// Leading zeros of the adder word and SW for an all-zero word
	function automatic fpalu_pkg::shamt_t lzc(input fpalu_pkg::sum_t w);
		fpalu_pkg::shamt_t n;
		n = fpalu_pkg::shamt_t'(SW);
		for (int k = 0; k < SW; k++) begin
			if (w[k])
				n = fpalu_pkg::shamt_t'(SW - 1 - k);	// Highest set bit wins
		end
		return n;
	endfunction

	// Stage 3 operand select and add
	always_comb begin
		if (i.op == fpalu_pkg::OP_MUL) begin
			add_l = {4'b0000, ps0};
			add_r = {1'b0, ps1, 1'b0, s2, 4'b0000};	// ps1 weight 2^6, s2 at 2^4
			add_c = 1'b0;
		end else begin
			add_l = i.lhs;
			add_r = i.rhs;
			add_c = i.sub;	// Completes the twos complement
		end
		add_y = add_l + add_r + SW'(add_c);
		if (i.op == fpalu_pkg::OP_MUL)
			add_y[SW-1] = 1'b0;	// Product is 22b so the constant overflow goes
	end

	always_ff @(posedge clk) begin
		op3 <= i.op;
		skip3 <= i.skip;
		age3 <= i.a_ge_b;
		sa3 <= i.sign_a;
		sb3 <= i.sign_b;
		ea3 <= i.exp_a;
		eb3 <= i.exp_b;
		if (i.valid && !i.skip)
			word_r <= add_y;
		if (i.valid && i.skip)
			byp_r <= i.lhs[SW-2:0];	// R unchanged and adder result unused
	end

	// Stage 4 leading-zero count
	always_ff @(posedge clk) begin
		op4 <= op3;
		skip4 <= skip3;
		age4 <= age3;
		sa4 <= sa3;
		sb4 <= sb3;
		ea4 <= ea3;
		eb4 <= eb3;
		lzc_r <= lzc(word_r);	// Idle across bypasses
		word4_r <= word_r;
		byp4_r <= byp_r;
	end

	// Valid chain
	always_ff @(posedge clk) begin
		if (rst) begin
			v3 <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v3 <= i.valid;
			out_valid <= v3;
		end
	end

	// Stage 5 normalize, exponent and sign
	always_comb begin
		norm_w = word4_r << lzc_r;
		l_exp = age4 ? ea4 : eb4;
		if (skip4) begin
			// R as it came in
			y_man = byp4_r;
			y_exp = age4 ? eb4 : ea4;
			y_sgn = age4 ? sb4 : sa4;
		end else if (op4 == fpalu_pkg::OP_MUL) begin
			y_man = norm_w[SW-1:1];
			y_exp = fpalu_pkg::exp_t'(ea4 + eb4 + fpalu_pkg::AL_EXP_BIAS + 2
				- 2 * fpalu_pkg::ML_EXP_BIAS - lzc_r);	// Wraps
			y_sgn = sa4 ^ sb4;
		end else begin
			y_man = norm_w[SW-1:1];
			y_exp = fpalu_pkg::exp_t'(l_exp + 1 - lzc_r);	// Guard bit adds one
			y_sgn = (sa4 ^ sb4) ? (sa4 ^ ~age4) : sa4;	// Subtract follows L
		end
	end

	// A result slot never carries undefined bits
	assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown({y_sgn, y_exp, y_man}));

endmodule

// ==== hw/fpalu_top.sv ====
/* Top of the FP29i adder / FP16 multiplier for the FIR datapath.
   One operation per clock, result on out_valid 4 cycles after sampling. */
module fpalu_top #(
	parameter int ALIGN_SHIFT_MAX = 32	// Alignment distance that flushes R
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,	// One-cycle strobe, no back-pressure
	input  fpalu_pkg::fpalu_op_t op,
	input  logic                 a_sgn,
	input  fpalu_pkg::exp_t      a_exp,	// Low 5b only on multiply
	input  fpalu_pkg::man_t      a_man,	// Low 10b only on multiply
	input  logic                 b_sgn,
	input  fpalu_pkg::exp_t      b_exp,
	input  fpalu_pkg::man_t      b_man,
	output logic                 out_valid,
	output logic                 y_sgn,
	output fpalu_pkg::exp_t      y_exp,
	output fpalu_pkg::man_t      y_man
);

	// Booth partial sums, registered alongside the operand bundle
	logic [fpalu_pkg::PP_BITS+6:0] ps0;	// pp0..pp2
	logic [fpalu_pkg::PP_BITS+3:0] ps1;	// pp3..pp5, weight 2^6
	logic                          s2;	// Deferred +1 of pp2

	fpalu_operand_if opnd_if ();

	// Stages 1-2, add path
	operand_align #(
		.ALIGN_SHIFT_MAX(ALIGN_SHIFT_MAX)
	) u_align (
		.clk     (clk),
		.rst     (rst),
		.in_valid(in_valid),
		.op      (op),
		.a_sgn   (a_sgn),
		.a_exp   (a_exp),
		.a_man   (a_man),
		.b_sgn   (b_sgn),
		.b_exp   (b_exp),
		.b_man   (b_man),
		.o       (opnd_if.front)
	);

	// Stages 1-2, multiply path
	booth_mul u_mul (
		.clk     (clk),
		.in_valid(in_valid),
		.op      (op),
		.a_exp   (a_exp),
		.a_man   (a_man),
		.b_exp   (b_exp),
		.b_man   (b_man),
		.ps0     (ps0),
		.ps1     (ps1),
		.s2      (s2)
	);

	// Stages 3-5, shared adder and normalizer
	sum_normalize u_norm (
		.clk      (clk),
		.rst      (rst),
		.i        (opnd_if.back),
		.ps0      (ps0),
		.ps1      (ps1),
		.s2       (s2),
		.out_valid(out_valid),
		.y_sgn    (y_sgn),
		.y_exp    (y_exp),
		.y_man    (y_man)
	);

endmodule

// ==== test/tb_fpalu_model.svh ====
/* Expected results of the FP29i add and the FP16 multiply, from the format rules.
   Included inside the testbench module. Results pack as {sign, exponent, mantissa}. */
`ifndef TB_FPALU_MODEL_SVH
`define TB_FPALU_MODEL_SVH

// Shift up until the top bit is set, zero word counts 23
function automatic int normalize_word(inout logic [22:0] w);
	int z;
	z = 0;
	while (z < 23 && !w[22]) begin
		w = w << 1;
		z++;
	end
	return z;
endfunction

function automatic logic [28:0] expected_sum(input logic sa, input logic [5:0] ea,
	input logic [21:0] ma, input logic sb, input logic [5:0] eb, input logic [21:0] mb);
	logic a_is_l;
	logic [5:0] el;
	logic [5:0] d;
	logic [21:0] ml;
	logic [21:0] mr;
	logic [21:0] mrs;
	logic [22:0] w;
	logic sy;
	int z;
	a_is_l = (ea >= eb);	// A wins a tie
	el = a_is_l ? ea : eb;
	ml = a_is_l ? ma : mb;
	mr = a_is_l ? mb : ma;
	d = a_is_l ? ea - eb : eb - ea;
	if (ml == '0)
		return a_is_l ? {sb, eb, mb} : {sa, ea, ma};	// R as it came in
	mrs = (d >= 6'd32) ? '0 : mr >> d;	// Truncating alignment
	if (sa == sb)
		w = {1'b0, ml} + {1'b0, mrs};
	else
		w = {1'b0, ml} - {1'b0, mrs};
	z = normalize_word(w);
	sy = (sa == sb) ? sa : sa ^ (ea < eb);
	return {sy, 6'(el + 1 - z), w[22:1]};	// Exponent wraps
endfunction

function automatic logic [28:0] expected_product(input logic sa, input logic [5:0] ea,
	input logic [21:0] ma, input logic sb, input logic [5:0] eb, input logic [21:0] mb);
	logic [4:0] xa;
	logic [4:0] xb;
	logic [10:0] siga;
	logic [10:0] sigb;
	logic [22:0] w;
	int z;
	xa = ea[4:0];	// FP16 fields only
	xb = eb[4:0];
	siga = (xa == '0) ? {ma[9:0], 1'b0} : {1'b1, ma[9:0]};	// Denormal moves up one
	sigb = (xb == '0) ? {mb[9:0], 1'b0} : {1'b1, mb[9:0]};
	w = 23'(siga) * 23'(sigb);	// 22b product
	z = normalize_word(w);
	return {sa ^ sb, 6'(xa + xb - 30 + 31 + 2 - z), w[22:1]};
endfunction

`endif

// ==== test/tb_fpalu.sv ====
/* Directed testbench for the FP29i add / FP16 multiply unit.
   Results are checked at the falling edge against the format model, in issue order. */
module tb_fpalu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_CYCLES = 16;
	localparam int LATENCY = 4;	// Drive cycle to result cycle
	localparam int N_ADD = 16;
	localparam int N_SUB = 12;
	localparam int N_BYP = 8;
	localparam int N_MUL = 16;
	localparam int N_MIX = 20;
	localparam int TOTAL_OPS = 1 + N_ADD + N_SUB + 2 + N_BYP + N_MUL + 3 + N_MIX;
	localparam int IDLE_CYCLES = 48;	// Quiet windows and drains
	localparam int MAX_CYCLES = RST_CYCLES + IDLE_CYCLES + TOTAL_OPS * LATENCY + 200;

	logic clk, rst, in_valid;
	fpalu_pkg::fpalu_op_t op;
	logic a_sgn, b_sgn;
	fpalu_pkg::exp_t a_exp, b_exp;
	fpalu_pkg::man_t a_man, b_man;
	logic out_valid, y_sgn;
	fpalu_pkg::exp_t y_exp;
	fpalu_pkg::man_t y_man;

	logic [31:0] lfsr;
	int cyc = 0;	// Rising edges so far
	int checks = 0;
	int errors = 0;
	logic [28:0] expect_q[$];	// {sign, exp, man} per operation in flight
	int issue_q[$];	// Drive cycle of each

	`include "tb_fpalu_model.svh"

	fpalu_top dut0 (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.op       (op),
		.a_sgn    (a_sgn),
		.a_exp    (a_exp),
		.a_man    (a_man),
		.b_sgn    (b_sgn),
		.b_exp    (b_exp),
		.b_man    (b_man),
		.out_valid(out_valid),
		.y_sgn    (y_sgn),
		.y_exp    (y_exp),
		.y_man    (y_man)
	);

	always #20 clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hA3000000 : lfsr >> 1;
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s expected %h got %h at cycle %0d", name, expected, actual, cyc);
		end
	endtask

	// One operation in the current cycle, expected result queued
	task automatic issue(input fpalu_pkg::fpalu_op_t o, input logic sa, input logic [5:0] ea,
		input logic [21:0] ma, input logic sb, input logic [5:0] eb, input logic [21:0] mb);
		in_valid = 1'b1;
		op = o;
		a_sgn = sa;
		a_exp = ea;
		a_man = ma;
		b_sgn = sb;
		b_exp = eb;
		b_man = mb;
		if (o == fpalu_pkg::OP_MUL)
			expect_q.push_back(expected_product(sa, ea, ma, sb, eb, mb));
		else
			expect_q.push_back(expected_sum(sa, ea, ma, sb, eb, mb));
		issue_q.push_back(cyc);
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// Wait until every queued result came out
	task automatic drain();
		while (expect_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("%-16s %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	task automatic same_sign_add(input int d);
		logic s;
		logic [5:0] lo, hi;
		logic [21:0] ma, mb;
		lo = 6'(rand_bits(6) % (64 - d));
		hi = 6'(lo + d);
		s = 1'(rand_bits(1));
		ma = 22'(rand_bits(22));
		mb = 22'(rand_bits(22));
		if (rand_bits(1) == 1)
			issue(fpalu_pkg::OP_ADD, s, hi, ma, s, lo, mb);
		else
			issue(fpalu_pkg::OP_ADD, s, lo, ma, s, hi, mb);
	endtask

	// L keeps the larger magnitude, top bit of L set k places down
	task automatic larger_l_sub(input int d);
		logic s;
		logic [5:0] el, er;
		logic [21:0] ml, mr;
		el = 6'(d + rand_bits(6) % (64 - d));
		er = 6'(el - d);
		ml = 22'((rand_bits(22) | 32'h200000) >> rand_bits(4));
		mr = 22'(rand_bits(22));
		if ((mr >> d) >= ml)
			mr = (d == 0) ? ml >> 1 : ml;
		s = 1'(rand_bits(1));
		if (d == 0 || rand_bits(1) == 1)	// Tie needs A as L
			issue(fpalu_pkg::OP_ADD, s, el, ml, ~s, er, mr);
		else
			issue(fpalu_pkg::OP_ADD, ~s, er, mr, s, el, ml);
	endtask

	task automatic zero_l_add(input int d);
		logic sl, sr;
		logic [5:0] el, er;
		logic [21:0] mr;
		el = 6'(d + rand_bits(6) % (64 - d));
		er = 6'(el - d);
		sl = 1'(rand_bits(1));
		sr = 1'(rand_bits(1));
		mr = 22'(rand_bits(22));
		if (d == 0 || rand_bits(1) == 1)
			issue(fpalu_pkg::OP_ADD, sl, el, 22'h0, sr, er, mr);
		else
			issue(fpalu_pkg::OP_ADD, sr, er, mr, sl, el, 22'h0);
	endtask

	// Upper field bits carry junk, the unit must ignore them
	task automatic random_mul();
		logic sa, sb;
		logic [5:0] ea, eb;
		logic [21:0] ma, mb;
		sa = 1'(rand_bits(1));
		sb = 1'(rand_bits(1));
		ea = 6'(rand_bits(6));
		eb = 6'(rand_bits(6));
		ma = 22'(rand_bits(22));
		mb = 22'(rand_bits(22));
		if (rand_bits(2) == 0)
			ea[4:0] = '0;	// Denormal
		if (rand_bits(2) == 0)
			eb[4:0] = '0;
		issue(fpalu_pkg::OP_MUL, sa, ea, ma, sb, eb, mb);
	endtask

	task automatic idle_and_single();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		idle(10);	// Any out_valid here is flagged by the monitor
		issue(fpalu_pkg::OP_ADD, 1'b0, 6'd40, 22'h2AAAAA, 1'b0, 6'd38, 22'h155555);
		drain();
		idle(8);
		report_test("latency", c0, e0);
	endtask

	task automatic aligned_adds();
		int c0, e0;
		int dlist[4] = '{0, 1, 21, 40};
		c0 = checks;
		e0 = errors;
		for (int k = 0; k < N_ADD; k++)
			same_sign_add((k < 8) ? dlist[k % 4] : int'(rand_bits(6) % 48));
		drain();
		report_test("add aligned", c0, e0);
	endtask

	task automatic cancelling_subs();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		issue(fpalu_pkg::OP_ADD, 1'b0, 6'd30, 22'h200005, 1'b1, 6'd30, 22'h200000);
		issue(fpalu_pkg::OP_ADD, 1'b1, 6'd45, 22'h100000, 1'b0, 6'd44, 22'h1FFFFE);
		for (int k = 0; k < N_SUB; k++)
			larger_l_sub(int'(rand_bits(5) % 25));
		drain();
		report_test("subtract", c0, e0);
	endtask

	task automatic zero_l_bypass();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		for (int k = 0; k < N_BYP; k++)
			zero_l_add((k == 0) ? 0 : 1 + int'(rand_bits(5) % 30));
		drain();
		report_test("zero bypass", c0, e0);
	endtask

	task automatic fp16_products();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		issue(fpalu_pkg::OP_MUL, 1'b0, 6'd15, 22'h0, 1'b1, 6'd15, 22'h0);	// 1.0 * -1.0
		issue(fpalu_pkg::OP_MUL, 1'b1, 6'd0, 22'h3FF, 1'b1, 6'd0, 22'h001);	// Both denormal
		issue(fpalu_pkg::OP_MUL, 1'b0, 6'd0, 22'h0, 1'b0, 6'd20, 22'h155);	// Zero product
		for (int k = 0; k < N_MUL; k++)
			random_mul();
		drain();
		report_test("multiply", c0, e0);
	endtask

	// One per cycle, up to four in flight
	task automatic mixed_stream();
		int c0, e0;
		c0 = checks;
		e0 = errors;
		for (int k = 0; k < N_MIX; k++) begin
			case (rand_bits(2) % 3)
				0: same_sign_add(int'(rand_bits(6) % 48));
				1: larger_l_sub(int'(rand_bits(5) % 25));
				default: random_mul();
			endcase
		end
		drain();
		report_test("mixed stream", c0, e0);
	endtask

	// Outputs settle after the rising edge, read them half a cycle later
	always @(negedge clk) begin
		logic [28:0] e;
		int t;
		if (!rst) begin
			if ($isunknown(out_valid)) begin
				errors++;
				$display("out_valid is unknown at cycle %0d", cyc);
			end else if (out_valid) begin
				if (expect_q.size() == 0) begin
					errors++;
					$display("out_valid high at cycle %0d with no operation in flight", cyc);
				end else begin
					e = expect_q.pop_front();
					t = issue_q.pop_front();
					check("latency", LATENCY, cyc - t);
					check("y_sgn", e[28], y_sgn);
					check("y_exp", e[27:22], y_exp);
					check("y_man", e[21:0], y_man);
				end
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout at cycle %0d, %0d results never came out", cyc, expect_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		op = fpalu_pkg::OP_ADD;
		a_sgn = 1'b0;
		a_exp = '0;
		a_man = '0;
		b_sgn = 1'b0;
		b_exp = '0;
		b_man = '0;
		lfsr = 32'h8c1af32f;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		idle_and_single();
		aligned_adds();
		cancelling_subs();
		zero_l_bypass();
		fp16_products();
		mixed_stream();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && expect_q.size() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+test
common/fpalu_pkg.sv
common/fpalu_operand_if.sv
hw/align/operand_align.sv
hw/mul/booth_mul.sv
hw/sum_normalize.sv
hw/fpalu_top.sv
test/tb_fpalu.sv

// ==== Bender.yml ====
package:
  name: fpalu

sources:
  - common/fpalu_pkg.sv
  - common/fpalu_operand_if.sv
  - hw/align/operand_align.sv
  - hw/mul/booth_mul.sv
  - hw/sum_normalize.sv
  - hw/fpalu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fpalu.sv
